// File: Bender.yml
package:
  name: csr_bank

sources:
  - source/csr_pkg.sv
  - source/csr_access_unit.sv
  - source/csr_trap_regs.sv
  - source/csr_counters.sv
  - source/csr_irq_ctrl.sv
  - source/csr_bank_top.sv
  - target: test
    files:
      - tests/csr_bank_assertions.sv
      - tests/csr_bank_tb.sv

// File: source/csr_access_unit.sv
/*
 * CSR access datapath
 * Decodes the CSR address into current value and write mask, forms the
 * written value for write, set and clear, and drives the read data
 */

`timescale 1ns/1ps

module csr_access_unit #(
    parameter bit             MUL_EXT_EN = 1'b1,
    parameter csr_pkg::xlen_t HART_ID    = '0
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                read_en_i,
    input  logic                write_en_i,
    input  csr_pkg::csr_op_e    op_i,
    input  csr_pkg::csr_addr_t  addr_i,
    input  csr_pkg::xlen_t      wdata_i,
    input  logic                killed_i,
    input  logic                mret_i,
    input  logic                raise_exc_i,
    input  logic                irq_ack_i,
    input  csr_pkg::xlen_t      mstatus_i,
    input  csr_pkg::xlen_t      mie_i,
    input  csr_pkg::xlen_t      mtvec_i,
    input  csr_pkg::xlen_t      mscratch_i,
    input  csr_pkg::xlen_t      mepc_i,
    input  csr_pkg::xlen_t      mcause_i,
    input  csr_pkg::xlen_t      mtval_i,
    input  csr_pkg::xlen_t      mip_i,
    input  csr_pkg::dword_t     mcycle_i,
    input  csr_pkg::dword_t     minstret_i,
    output csr_pkg::xlen_t      rdata_o,
    output logic                wr_en_o,
    output csr_pkg::csr_addr_t  wr_addr_o,
    output csr_pkg::xlen_t      wr_data_o
);

    import csr_pkg::*;

    // MXL = 32 bit, U and I present, M from the parameter
    localparam xlen_t MISA_VALUE = 32'h4010_0100 | (xlen_t'(MUL_EXT_EN) << 12);

    xlen_t current_val;
    xlen_t wmask;

    always_comb begin
        case (addr_i)
            ADDR_MSTATUS:   begin current_val = mstatus_i;        wmask = MSTATUS_WMASK; end
            ADDR_MIE:       begin current_val = mie_i;            wmask = MIE_WMASK;     end
            ADDR_MTVEC:     begin current_val = mtvec_i;          wmask = ALIGN_WMASK;   end
            ADDR_MSCRATCH:  begin current_val = mscratch_i;       wmask = FULL_WMASK;    end
            ADDR_MEPC:      begin current_val = mepc_i;           wmask = ALIGN_WMASK;   end
            ADDR_MCAUSE:    begin current_val = mcause_i;         wmask = FULL_WMASK;    end
            ADDR_MTVAL:     begin current_val = mtval_i;          wmask = FULL_WMASK;    end
            ADDR_MCYCLE:    begin current_val = mcycle_i[31:0];   wmask = FULL_WMASK;    end
            ADDR_MCYCLEH:   begin current_val = mcycle_i[63:32];  wmask = FULL_WMASK;    end
            ADDR_MINSTRET:  begin current_val = minstret_i[31:0]; wmask = FULL_WMASK;    end
            ADDR_MINSTRETH: begin current_val = minstret_i[63:32]; wmask = FULL_WMASK;   end
            default:        begin current_val = '0;               wmask = '0;            end
        endcase
    end

    always_comb begin
        case (op_i)
            CSR_WRITE: wr_data_o = (current_val & ~wmask) | (wdata_i & wmask);
            CSR_SET:   wr_data_o = current_val | (wdata_i & wmask);
            CSR_CLEAR: wr_data_o = current_val & ~(wdata_i & wmask);
            default:   wr_data_o = current_val; // Undefined op leaves the CSR alone
        endcase
    end

    // Traps and returns take the slot of a CSR write
    assign wr_en_o   = write_en_i & ~killed_i & ~mret_i & ~raise_exc_i & ~irq_ack_i;
    assign wr_addr_o = addr_i;

    ////////////////////////////////////////////////////////////
    // Read multiplexer
    ////////////////////////////////////////////////////////////

    always_comb begin
        rdata_o = '0;
        if (read_en_i && !killed_i) begin
            case (addr_i)
                ADDR_MSTATUS:                 rdata_o = mstatus_i;
                ADDR_MISA:                    rdata_o = MISA_VALUE;
                ADDR_MIE:                     rdata_o = mie_i;
                ADDR_MTVEC:                   rdata_o = mtvec_i;
                ADDR_MSCRATCH:                rdata_o = mscratch_i;
                ADDR_MEPC:                    rdata_o = mepc_i;
                ADDR_MCAUSE:                  rdata_o = mcause_i;
                ADDR_MTVAL:                   rdata_o = mtval_i;
                ADDR_MIP:                     rdata_o = mip_i;
                ADDR_MCYCLE, ADDR_CYCLE:      rdata_o = mcycle_i[31:0];
                ADDR_MCYCLEH, ADDR_CYCLEH:    rdata_o = mcycle_i[63:32];
                ADDR_MINSTRET, ADDR_INSTRET:  rdata_o = minstret_i[31:0];
                ADDR_MINSTRETH, ADDR_INSTRETH: rdata_o = minstret_i[63:32];
                ADDR_MHARTID:                 rdata_o = HART_ID;
                default:                      rdata_o = '0;
            endcase
        end
    end

endmodule

// File: source/csr_bank_top.sv
/*
 * Machine-mode CSR bank
 * Connects the access datapath, trap registers, counters and
 * interrupt control
 */

`timescale 1ns/1ps

module csr_bank_top #(
    parameter bit             MUL_EXT_EN = 1'b1,
    parameter csr_pkg::xlen_t HART_ID    = '0
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                read_en_i,
    input  logic                write_en_i,
    input  csr_pkg::csr_op_e    op_i,
    input  csr_pkg::csr_addr_t  addr_i,
    input  csr_pkg::xlen_t      wdata_i,
    input  logic                killed_i,
    input  logic                hold_i,
    input  logic                raise_exc_i,
    input  csr_pkg::exc_code_t  exc_code_i,
    input  csr_pkg::xlen_t      pc_i,
    input  csr_pkg::xlen_t      instr_i,
    input  logic                mret_i,
    input  logic                irq_ack_i,
    input  logic                jump_i,
    input  csr_pkg::xlen_t      jump_target_i,
    input  csr_pkg::xlen_t      irq_i,
    output csr_pkg::xlen_t      rdata_o,
    output logic                irq_pending_o,
    output csr_pkg::priv_e      privilege_o,
    output csr_pkg::xlen_t      mepc_o,
    output csr_pkg::xlen_t      mtvec_o
);

    import csr_pkg::*;

    logic      wr_en;
    csr_addr_t wr_addr;
    xlen_t     wr_data;
    xlen_t     mstatus, mie, mscratch, mcause, mtval, mip;
    dword_t    mcycle, minstret;
    logic      mstatus_mie;
    irq_code_e irq_code;

    csr_access_unit #(
        .MUL_EXT_EN (MUL_EXT_EN),
        .HART_ID    (HART_ID)
    ) u_access (
        .clk         (clk),
        .reset_n     (reset_n),
        .read_en_i   (read_en_i),
        .write_en_i  (write_en_i),
        .op_i        (op_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .killed_i    (killed_i),
        .mret_i      (mret_i),
        .raise_exc_i (raise_exc_i),
        .irq_ack_i   (irq_ack_i),
        .mstatus_i   (mstatus),
        .mie_i       (mie),
        .mtvec_i     (mtvec_o),
        .mscratch_i  (mscratch),
        .mepc_i      (mepc_o),
        .mcause_i    (mcause),
        .mtval_i     (mtval),
        .mip_i       (mip),
        .mcycle_i    (mcycle),
        .minstret_i  (minstret),
        .rdata_o     (rdata_o),
        .wr_en_o     (wr_en),
        .wr_addr_o   (wr_addr),
        .wr_data_o   (wr_data)
    );

    csr_trap_regs u_trap (
        .clk           (clk),
        .reset_n       (reset_n),
        .wr_en_i       (wr_en),
        .wr_addr_i     (wr_addr),
        .wr_data_i     (wr_data),
        .mret_i        (mret_i),
        .raise_exc_i   (raise_exc_i),
        .exc_code_i    (exc_code_i),
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .irq_ack_i     (irq_ack_i),
        .irq_code_i    (irq_code),
        .jump_i        (jump_i),
        .jump_target_i (jump_target_i),
        .mstatus_o     (mstatus),
        .mie_o         (mie),
        .mtvec_o       (mtvec_o),
        .mscratch_o    (mscratch),
        .mepc_o        (mepc_o),
        .mcause_o      (mcause),
        .mtval_o       (mtval),
        .mstatus_mie_o (mstatus_mie),
        .privilege_o   (privilege_o)
    );

    csr_counters u_counters (
        .clk        (clk),
        .reset_n    (reset_n),
        .wr_en_i    (wr_en),
        .wr_addr_i  (wr_addr),
        .wr_data_i  (wr_data),
        .killed_i   (killed_i),
        .hold_i     (hold_i),
        .mcycle_o   (mcycle),
        .minstret_o (minstret)
    );

    csr_irq_ctrl u_irq (
        .clk           (clk),
        .reset_n       (reset_n),
        .irq_i         (irq_i),
        .mie_i         (mie),
        .mstatus_mie_i (mstatus_mie),
        .irq_ack_i     (irq_ack_i),
        .mip_o         (mip),
        .irq_pending_o (irq_pending_o),
        .irq_code_o    (irq_code)
    );

endmodule

// File: source/csr_counters.sv
/*
 * Cycle and retired-instruction counters
 * 64-bit mcycle and minstret, each half writable as a CSR
 */

`timescale 1ns/1ps

module csr_counters (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                wr_en_i,
    input  csr_pkg::csr_addr_t  wr_addr_i,
    input  csr_pkg::xlen_t      wr_data_i,
    input  logic                killed_i,
    input  logic                hold_i,
    output csr_pkg::dword_t     mcycle_o,
    output csr_pkg::dword_t     minstret_o
);

    import csr_pkg::*;

    dword_t mcycle_q, mcycle_nxt;
    dword_t minstret_q, minstret_nxt;

    always_comb begin
        mcycle_nxt   = mcycle_q + 64'd1;
        minstret_nxt = (killed_i || hold_i) ? minstret_q : minstret_q + 64'd1;
        // A CSR write wins over the increment
        if (wr_en_i) begin
            case (wr_addr_i)
                ADDR_MCYCLE:    mcycle_nxt   = {mcycle_q[63:32], wr_data_i};
                ADDR_MCYCLEH:   mcycle_nxt   = {wr_data_i, mcycle_q[31:0]};
                ADDR_MINSTRET:  minstret_nxt = {minstret_q[63:32], wr_data_i};
                ADDR_MINSTRETH: minstret_nxt = {wr_data_i, minstret_q[31:0]};
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q   <= mcycle_nxt;
            minstret_q <= minstret_nxt;
        end
    end

    assign mcycle_o   = mcycle_q;
    assign minstret_o = minstret_q;

endmodule

// File: source/csr_irq_ctrl.sv
/*
 * Interrupt control
 * Samples the interrupt lines into mip, flags an enabled pending
 * interrupt and registers its cause
 */

`timescale 1ns/1ps

module csr_irq_ctrl (
    input  logic                clk,
    input  logic                reset_n,
    input  csr_pkg::xlen_t      irq_i,
    input  csr_pkg::xlen_t      mie_i,
    input  logic                mstatus_mie_i,
    input  logic                irq_ack_i,
    output csr_pkg::xlen_t      mip_o,
    output logic                irq_pending_o,
    output csr_pkg::irq_code_e  irq_code_o
);

    import csr_pkg::*;

    xlen_t mip_q;
    xlen_t enabled;

    assign enabled = mip_q & mie_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mip_q         <= '0;
            irq_pending_o <= 1'b0;
            irq_code_o    <= irq_code_e'('0);
        end else begin
            mip_q         <= irq_i;
            irq_pending_o <= 1'b0;
            if (mstatus_mie_i && (enabled != '0) && !irq_ack_i) begin
                irq_pending_o <= 1'b1;
                if (enabled[IRQ_MEI_BIT])      irq_code_o <= IRQ_M_EXT;   // Highest
                else if (enabled[IRQ_MSI_BIT]) irq_code_o <= IRQ_M_SW;
                else if (enabled[IRQ_MTI_BIT]) irq_code_o <= IRQ_M_TIMER;
            end
        end
    end

    assign mip_o = mip_q;

endmodule

// File: source/csr_pkg.sv
/*
 * CSR bank definitions
 * Shared widths, CSR addresses, write masks and encodings for the
 * machine-mode control and status register bank
 */

package csr_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] xlen_t;     // One CSR word
    typedef logic [63:0] dword_t;    // Full counter value
    typedef logic [11:0] csr_addr_t;
    typedef logic [4:0]  exc_code_t; // Synchronous exception code

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        CSR_WRITE = 2'd0,
        CSR_SET   = 2'd1,
        CSR_CLEAR = 2'd2
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'd0,
        PRIV_MACHINE = 2'd3
    } priv_e;

    // Value of the low mcause bits for an interrupt
    typedef enum logic [4:0] {
        IRQ_M_SW    = 5'd3,
        IRQ_M_TIMER = 5'd7,
        IRQ_M_EXT   = 5'd11
    } irq_code_e;

    ////////////////////////////////////////////////////////////
    // Addresses
    ////////////////////////////////////////////////////////////

    localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
    localparam csr_addr_t ADDR_MISA      = 12'h301;
    localparam csr_addr_t ADDR_MIE       = 12'h304;
    localparam csr_addr_t ADDR_MTVEC     = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
    localparam csr_addr_t ADDR_MEPC      = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
    localparam csr_addr_t ADDR_MTVAL     = 12'h343;
    localparam csr_addr_t ADDR_MIP       = 12'h344;
    localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
    localparam csr_addr_t ADDR_MINSTRET  = 12'hB02;
    localparam csr_addr_t ADDR_MCYCLEH   = 12'hB80;
    localparam csr_addr_t ADDR_MINSTRETH = 12'hB82;
    localparam csr_addr_t ADDR_CYCLE     = 12'hC00; // User read-only aliases
    localparam csr_addr_t ADDR_INSTRET   = 12'hC02;
    localparam csr_addr_t ADDR_CYCLEH    = 12'hC80;
    localparam csr_addr_t ADDR_INSTRETH  = 12'hC82;
    localparam csr_addr_t ADDR_MHARTID   = 12'hF14;

    // Write masks
    localparam xlen_t MSTATUS_WMASK = 32'h0000_1888; // MIE, MPIE, MPP
    localparam xlen_t MIE_WMASK     = 32'h0000_0888; // MSIE, MTIE, MEIE
    localparam xlen_t ALIGN_WMASK   = 32'hFFFF_FFFC;
    localparam xlen_t FULL_WMASK    = 32'hFFFF_FFFF;

    // Bit positions
    localparam int unsigned MSTATUS_MIE_BIT  = 3;
    localparam int unsigned MSTATUS_MPIE_BIT = 7;
    localparam int unsigned MSTATUS_MPP_LSB  = 11;
    localparam int unsigned IRQ_MSI_BIT      = 3;
    localparam int unsigned IRQ_MTI_BIT      = 7;
    localparam int unsigned IRQ_MEI_BIT      = 11;

    localparam exc_code_t EXC_ILLEGAL_INSTR = 5'd2;
    localparam xlen_t     INSN_BYTES        = 32'd4;

endpackage

// File: source/csr_trap_regs.sv
/*
 * Machine trap registers
 * Holds mstatus, mie, mtvec, mscratch, mepc, mcause, mtval and the
 * privilege level, updated by return, trap entry and CSR writes
 */

`timescale 1ns/1ps

module csr_trap_regs (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                wr_en_i,
    input  csr_pkg::csr_addr_t  wr_addr_i,
    input  csr_pkg::xlen_t      wr_data_i,
    input  logic                mret_i,
    input  logic                raise_exc_i,
    input  csr_pkg::exc_code_t  exc_code_i,
    input  csr_pkg::xlen_t      pc_i,
    input  csr_pkg::xlen_t      instr_i,
    input  logic                irq_ack_i,
    input  csr_pkg::irq_code_e  irq_code_i,
    input  logic                jump_i,
    input  csr_pkg::xlen_t      jump_target_i,
    output csr_pkg::xlen_t      mstatus_o,
    output csr_pkg::xlen_t      mie_o,
    output csr_pkg::xlen_t      mtvec_o,
    output csr_pkg::xlen_t      mscratch_o,
    output csr_pkg::xlen_t      mepc_o,
    output csr_pkg::xlen_t      mcause_o,
    output csr_pkg::xlen_t      mtval_o,
    output logic                mstatus_mie_o,
    output csr_pkg::priv_e      privilege_o
);

    import csr_pkg::*;

    logic  mie_bit_q;   // mstatus.MIE
    logic  mpie_bit_q;  // mstatus.MPIE
    priv_e mpp_q;       // mstatus.MPP
    priv_e priv_q;
    xlen_t mie_q, mtvec_q, mscratch_q, mepc_q, mcause_q, mtval_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mie_bit_q  <= 1'b0;
            mpie_bit_q <= 1'b0;
            mpp_q      <= PRIV_USER;
            priv_q     <= PRIV_MACHINE;
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end else if (mret_i) begin
            mie_bit_q <= mpie_bit_q;
            priv_q    <= mpp_q;
        end else if (raise_exc_i || irq_ack_i) begin
            // Common trap entry
            mpp_q      <= priv_q;
            priv_q     <= PRIV_MACHINE;
            mpie_bit_q <= mie_bit_q;
            mie_bit_q  <= 1'b0;
            if (raise_exc_i) begin
                mepc_q   <= pc_i;
                mcause_q <= {1'b0, 26'b0, exc_code_i};
                mtval_q  <= (exc_code_i == EXC_ILLEGAL_INSTR) ? instr_i : pc_i;
            end else begin
                // Current instruction retires before the interrupt is taken
                mepc_q   <= jump_i ? jump_target_i : pc_i + INSN_BYTES;
                mcause_q <= {1'b1, 26'b0, irq_code_i};
            end
        end else if (wr_en_i) begin
            case (wr_addr_i)
                ADDR_MSTATUS: begin
                    mie_bit_q  <= wr_data_i[MSTATUS_MIE_BIT];
                    mpie_bit_q <= wr_data_i[MSTATUS_MPIE_BIT];
                    // Only user and machine exist, other MPP codes fall to user
                    mpp_q <= (wr_data_i[MSTATUS_MPP_LSB +: 2] == PRIV_MACHINE) ?
                             PRIV_MACHINE : PRIV_USER;
                end
                ADDR_MIE:      mie_q      <= wr_data_i;
                ADDR_MTVEC:    mtvec_q    <= wr_data_i;
                ADDR_MSCRATCH: mscratch_q <= wr_data_i;
                ADDR_MEPC:     mepc_q     <= wr_data_i;
                ADDR_MCAUSE:   mcause_q   <= wr_data_i;
                ADDR_MTVAL:    mtval_q    <= wr_data_i;
                default: ;
            endcase
        end
    end

    // Unimplemented mstatus fields read as zero
    always_comb begin
        mstatus_o                            = '0;
        mstatus_o[MSTATUS_MIE_BIT]           = mie_bit_q;
        mstatus_o[MSTATUS_MPIE_BIT]          = mpie_bit_q;
        mstatus_o[MSTATUS_MPP_LSB +: 2]      = mpp_q;
    end

    assign mie_o         = mie_q;
    assign mtvec_o       = mtvec_q;
    assign mscratch_o    = mscratch_q;
    assign mepc_o        = mepc_q;
    assign mcause_o      = mcause_q;
    assign mtval_o       = mtval_q;
    assign mstatus_mie_o = mie_bit_q;
    assign privilege_o   = priv_q;

endmodule

// File: src.f
source/csr_pkg.sv
source/csr_access_unit.sv
source/csr_trap_regs.sv
source/csr_counters.sv
source/csr_irq_ctrl.sv
source/csr_bank_top.sv
tests/csr_bank_assertions.sv
tests/csr_bank_tb.sv

// File: tests/csr_bank_assertions.sv
/*
 * CSR bank checker
 * Concurrent assertions on read gating, trap entry, return and
 * interrupt acknowledge, bound to the top level
 */

`timescale 1ns/1ps

module csr_bank_assertions (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                read_en_i,
    input  logic                killed_i,
    input  logic                raise_exc_i,
    input  logic                mret_i,
    input  logic                irq_ack_i,
    input  csr_pkg::xlen_t      pc_i,
    input  csr_pkg::xlen_t      rdata_o,
    input  csr_pkg::xlen_t      mepc_o,
    input  csr_pkg::xlen_t      mtvec_o,
    input  csr_pkg::xlen_t      mstatus,
    input  csr_pkg::xlen_t      mcause,
    input  logic                irq_pending_o,
    input  csr_pkg::priv_e      privilege_o
);

    import csr_pkg::*;

    int error_count = 0;    // Watched by the testbench

    // No read data unless a live read is presented
    read_gating: assert property (@(posedge clk) disable iff (!reset_n)
        (!read_en_i || killed_i) |-> (rdata_o == '0))
        else begin
            $error("rdata_o not zero without a live read");
            error_count++;
        end

    // Exception entry saves pc and moves to machine mode
    exc_entry: assert property (@(posedge clk) disable iff (!reset_n)
        (raise_exc_i && !mret_i) |=> (mepc_o == $past(pc_i)) && (privilege_o == PRIV_MACHINE))
        else begin
            $error("exception entry did not save pc or raise privilege");
            error_count++;
        end

    // Return goes to the privilege held in MPP
    mret_priv: assert property (@(posedge clk) disable iff (!reset_n)
        mret_i |=> (privilege_o == priv_e'($past(mstatus[MSTATUS_MPP_LSB +: 2]))))
        else begin
            $error("machine return did not restore MPP");
            error_count++;
        end

    // Acknowledge records an interrupt cause and drops pending
    irq_entry: assert property (@(posedge clk) disable iff (!reset_n)
        (irq_ack_i && !mret_i && !raise_exc_i) |=>
            mcause[31] && !irq_pending_o && (privilege_o == PRIV_MACHINE))
        else begin
            $error("interrupt acknowledge left wrong cause or pending");
            error_count++;
        end

    // Trap vector is always word aligned
    mtvec_align: assert property (@(posedge clk) disable iff (!reset_n)
        mtvec_o[1:0] == 2'b00)
        else begin
            $error("mtvec holds a misaligned base");
            error_count++;
        end

endmodule

bind csr_bank_top csr_bank_assertions u_checks (
    .clk           (clk),
    .reset_n       (reset_n),
    .read_en_i     (read_en_i),
    .killed_i      (killed_i),
    .raise_exc_i   (raise_exc_i),
    .mret_i        (mret_i),
    .irq_ack_i     (irq_ack_i),
    .pc_i          (pc_i),
    .rdata_o       (rdata_o),
    .mepc_o        (mepc_o),
    .mtvec_o       (mtvec_o),
    .mstatus       (mstatus),
    .mcause        (mcause),
    .irq_pending_o (irq_pending_o),
    .privilege_o   (privilege_o)
);

// File: tests/csr_bank_tb.sv
/*
 * CSR bank testbench
 * Drives reset, CSR access, traps, interrupts and counters
 */

`timescale 1ns/1ps

module csr_bank_tb;

    import csr_pkg::*;

    localparam int MAX_CYCLES = 400;

    logic      clk = 1'b0;
    logic      reset_n = 1'b0;
    logic      read_en_i = 1'b0, write_en_i = 1'b0, killed_i = 1'b0, hold_i = 1'b0;
    csr_op_e   op_i = CSR_WRITE;
    csr_addr_t addr_i = '0;
    xlen_t     wdata_i = '0, pc_i = '0, instr_i = '0, jump_target_i = '0, irq_i = '0;
    logic      raise_exc_i = 1'b0, mret_i = 1'b0, irq_ack_i = 1'b0, jump_i = 1'b0;
    exc_code_t exc_code_i = '0;
    xlen_t     rdata_o, mepc_o, mtvec_o;
    logic      irq_pending_o;
    priv_e     privilege_o;

    int    cycles = 0;
    int    errors = 0;
    xlen_t rng = 32'd50;

    csr_bank_top #(.MUL_EXT_EN(1'b1), .HART_ID(32'd0)) UUT (.*);

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "Run stopped on first error");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) fail_run("Timeout, the run did not finish in time");
    end

    always @(negedge clk) begin
        if (UUT.u_checks.error_count != 0) fail_run("A concurrent assertion failed");
    end

    function automatic xlen_t xorshift32(input xlen_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Write rule applied through a register mask
    function automatic xlen_t masked_update(input xlen_t cur, input xlen_t data,
                                            input xlen_t mask, input csr_op_e op);
        if (op == CSR_SET) return cur | (data & mask);
        if (op == CSR_CLEAR) return cur & ~(data & mask);
        return (cur & ~mask) | (data & mask);
    endfunction

    task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
        assert (expected === actual)
        else begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
            fail_run("Value mismatch");
        end
    endtask

    // Presents a write for one cycle, returns at the next falling edge
    task automatic csr_write(input csr_addr_t addr, input csr_op_e op, input xlen_t data,
                             input logic kill);
        @(negedge clk);
        read_en_i  = 1'b0;
        write_en_i = 1'b1;
        killed_i   = kill;
        op_i       = op;
        addr_i     = addr;
        wdata_i    = data;
        @(negedge clk);
        write_en_i = 1'b0;
        killed_i   = 1'b0;
    endtask

    // Combinational read in the current cycle
    task automatic csr_read(input csr_addr_t addr, output xlen_t data);
        read_en_i = 1'b1;
        addr_i    = addr;
        #1;
        data      = rdata_o;
        read_en_i = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    initial begin
        xlen_t   val, val2, model_scratch, model_tvec, data, pc_val;
        csr_op_e op;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Reset state
        check_value("reset_priv", PRIV_MACHINE, xlen_t'(privilege_o));
        check_value("reset_pending", 32'd0, xlen_t'(irq_pending_o));
        check_value("reset_mepc", 32'd0, mepc_o);
        check_value("reset_mtvec", 32'd0, mtvec_o);
        csr_read(ADDR_MSTATUS, val);
        check_value("reset_mstatus", 32'd0, val);

        // Masked write, set and clear
        model_scratch = '0;
        model_tvec    = '0;
        for (int i = 0; i < 3; i++) begin
            op  = csr_op_e'(i);
            rng = xorshift32(rng);
            data = rng;
            csr_write(ADDR_MSCRATCH, op, data, 1'b0);
            model_scratch = masked_update(model_scratch, data, FULL_WMASK, op);
            csr_read(ADDR_MSCRATCH, val);
            check_value("mscratch_access", model_scratch, val);
            rng = xorshift32(rng);
            data = rng;
            csr_write(ADDR_MTVEC, op, data, 1'b0);
            model_tvec = masked_update(model_tvec, data, ALIGN_WMASK, op);
            check_value("mtvec_out", model_tvec, mtvec_o);
            csr_read(ADDR_MTVEC, val);
            check_value("mtvec_access", model_tvec, val);
        end
        csr_write(ADDR_MSCRATCH, CSR_WRITE, ~model_scratch, 1'b1);
        csr_read(ADDR_MSCRATCH, val);
        check_value("killed_write", model_scratch, val);
        killed_i = 1'b1;
        csr_read(ADDR_MSCRATCH, val);
        killed_i = 1'b0;
        check_value("killed_read", 32'd0, val);

        // Machine return to user with MPIE set
        csr_write(ADDR_MSTATUS, CSR_WRITE, 32'h0000_0080, 1'b0);
        mret_i = 1'b1;
        @(negedge clk);
        mret_i = 1'b0;
        check_value("mret_priv", PRIV_USER, xlen_t'(privilege_o));
        csr_read(ADDR_MSTATUS, val);
        check_value("mret_mie", 32'd1, xlen_t'(val[MSTATUS_MIE_BIT]));

        // Illegal-instruction exception taken from user mode
        @(negedge clk);
        rng         = xorshift32(rng);
        pc_val      = rng & ALIGN_WMASK;
        pc_i        = pc_val;
        rng         = xorshift32(rng);
        instr_i     = rng;
        exc_code_i  = EXC_ILLEGAL_INSTR;
        raise_exc_i = 1'b1;
        @(negedge clk);
        raise_exc_i = 1'b0;
        check_value("exc_mepc", pc_val, mepc_o);
        check_value("exc_priv", PRIV_MACHINE, xlen_t'(privilege_o));
        csr_read(ADDR_MTVAL, val);
        check_value("exc_mtval", instr_i, val);
        csr_read(ADDR_MCAUSE, val);
        check_value("exc_mcause", 32'd2, val);

        // External interrupt taken on a jump
        csr_write(ADDR_MSTATUS, CSR_SET, 32'h0000_0008, 1'b0);
        csr_write(ADDR_MIE, CSR_WRITE, 32'h0000_0800, 1'b0);
        irq_i[IRQ_MEI_BIT] = 1'b1;
        @(negedge clk);
        check_value("irq_pending_early", 32'd0, xlen_t'(irq_pending_o));
        @(negedge clk);
        check_value("irq_pending", 32'd1, xlen_t'(irq_pending_o));
        rng           = xorshift32(rng);
        jump_target_i = rng & ALIGN_WMASK;
        jump_i        = 1'b1;
        irq_ack_i     = 1'b1;
        @(negedge clk);
        irq_ack_i = 1'b0;
        jump_i    = 1'b0;
        irq_i     = '0;
        check_value("irq_mepc", jump_target_i, mepc_o);
        check_value("irq_pending_after_ack", 32'd0, xlen_t'(irq_pending_o));
        csr_read(ADDR_MCAUSE, val);
        check_value("irq_mcause", 32'h8000_000B, val);

        // Counters
        @(negedge clk);
        csr_read(ADDR_MCYCLE, val);
        @(negedge clk);
        csr_read(ADDR_MCYCLE, val2);
        check_value("mcycle_step", val + 32'd1, val2);
        rng  = xorshift32(rng);
        data = rng;
        csr_write(ADDR_MCYCLE, CSR_WRITE, data, 1'b0);
        csr_read(ADDR_MCYCLE, val);
        check_value("mcycle_written", data, val);
        @(negedge clk);
        csr_read(ADDR_MCYCLE, val);
        check_value("mcycle_after_write", data + 32'd1, val);
        hold_i = 1'b1;
        @(negedge clk);
        csr_read(ADDR_MINSTRET, val);
        repeat (3) @(negedge clk);
        csr_read(ADDR_MINSTRET, val2);
        check_value("minstret_hold", val, val2);
        hold_i = 1'b0;

        repeat (2) @(negedge clk);
        if (errors == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_run("Checks reported errors");
        end
    end

endmodule
